// File: rtl/crcgc_macros.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CRC-32 generate/check block.
// Data path, register port and counter widths, and the
// word addresses of the register map.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CRCGC_MACROS_SVH
`define CRCGC_MACROS_SVH

`define CRCGC_DATA_W 32   // Stream beat width.
`define CRCGC_ADDR_W 4    // Register word address.
`define CRCGC_CNT_W  16   // Frame and error counters.

// Register map.
`define CRCGC_ADDR_CTRL     4'd0
`define CRCGC_ADDR_STATUS   4'd1
`define CRCGC_ADDR_FRAMES   4'd2
`define CRCGC_ADDR_ERRORS   4'd3
`define CRCGC_ADDR_LAST_CRC 4'd4

`endif

// File: rtl/crcgc_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CRC-32 generate/check types.
// Mode encoding, stream beat layouts and the reflected
// CRC-32 update functions.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "crcgc_macros.svh"

package crcgc_pkg;

  localparam logic [31:0] CRC_POLY   = 32'hEDB8_8320; // Reflected 04C11DB7.
  localparam logic [31:0] CRC_INIT   = 32'hFFFF_FFFF;
  localparam logic [31:0] CRC_XOROUT = 32'hFFFF_FFFF;

  // Value 3 is unused and treated as pass.
  typedef enum logic [1:0] {
    MODE_PASS = 2'd0,
    MODE_GEN  = 2'd1,
    MODE_CHK  = 2'd2
  } crcgc_mode_e;

  typedef struct packed {
    logic [`CRCGC_DATA_W-1:0] data;
    logic                     last;
  } in_beat_t;

  typedef struct packed {
    logic [`CRCGC_DATA_W-1:0] data;
    logic                     last;
    logic                     err;  // Check failed, only on last.
  } out_beat_t;

  // One byte, bit serial, LSB first.
  function automatic logic [31:0] crc32_byte(input logic [31:0] crc,
                                             input logic [7:0]  data);
    logic [31:0] c;
    c = crc ^ {24'd0, data};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  // Whole word, least significant byte first.
  function automatic logic [31:0] crc32_word(input logic [31:0] crc,
                                             input logic [31:0] data);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 4; i++) begin
      c = crc32_byte(c, data[8*i +: 8]);
    end
    return c;
  endfunction

endpackage

// File: rtl/stream_skid_buf.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready skid buffer.
// Main plus skid register: registered ready and data, full
// throughput, any packed payload type.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module stream_skid_buf #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     arst_n,

  input  logic     s_valid,
  output logic     s_ready,
  input  payload_t s_data,

  output logic     m_valid,
  input  logic     m_ready,
  output payload_t m_data
);

  logic     skid_valid;
  logic     main_load;
  payload_t skid_data;

  assign main_load = m_ready || !m_valid; // Main register free this cycle.
  assign s_ready   = !skid_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      m_valid    <= skid_valid || s_valid;
      skid_valid <= 1'b0;
    end else if (s_valid && s_ready) begin
      skid_valid <= 1'b1;  // Output stalled, park the beat.
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      m_data <= skid_valid ? skid_data : s_data;
    end
    if (!main_load && s_valid && s_ready) begin
      skid_data <= s_data;
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("skid buffer output changed while stalled");

endmodule

// File: rtl/crcgc_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CRC-32 engine and frame sequencer.
// Pass, generate (append CRC beat) and check (compare final
// beat) modes, mode latched per frame.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module crcgc_core (
  input  logic                   clk,
  input  logic                   arst_n,

  input  logic                   s_valid,
  output logic                   s_ready,
  input  crcgc_pkg::in_beat_t    s_beat,

  output logic                   m_valid,
  input  logic                   m_ready,
  output crcgc_pkg::out_beat_t   m_beat,

  input  crcgc_pkg::crcgc_mode_e mode,

  output logic                   frame_done,
  output logic                   crc_err,
  output logic [31:0]            last_crc
);

  import crcgc_pkg::*;

  logic        slot_free;
  logic        take;
  logic        emit_crc;
  logic        in_frame;
  logic        gen_pend;
  crcgc_mode_e frm_mode;
  crcgc_mode_e cur_mode;
  logic        is_gen;
  logic        is_chk;
  logic        chk_bad;
  logic [31:0] crc_q;
  logic [31:0] crc_base;
  logic [31:0] crc_next;
  logic [31:0] crc_gen;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake and CRC datapath
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign slot_free = !m_valid || m_ready;
  assign s_ready   = slot_free && !gen_pend; // Held off during CRC insert.
  assign take      = s_valid && s_ready;
  assign emit_crc  = gen_pend && slot_free;

  assign cur_mode = in_frame ? frm_mode : mode; // First beat samples mode.
  assign is_gen   = (cur_mode == MODE_GEN);
  assign is_chk   = (cur_mode == MODE_CHK);

  assign crc_base = in_frame ? crc_q : CRC_INIT;
  assign crc_next = crc32_word(crc_base, s_beat.data);
  assign crc_gen  = crc_q ^ CRC_XOROUT;

  // Last beat against the CRC of every beat before it.
  assign chk_bad = (s_beat.data != (crc_base ^ CRC_XOROUT));

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame sequencing
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid    <= 1'b0;
      in_frame   <= 1'b0;
      gen_pend   <= 1'b0;
      frm_mode   <= MODE_PASS;
      crc_q      <= CRC_INIT;
      frame_done <= 1'b0;
      crc_err    <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      crc_err    <= 1'b0;
      if (slot_free) begin
        m_valid <= take || gen_pend;
      end
      if (emit_crc) begin
        gen_pend   <= 1'b0;
        frame_done <= 1'b1;
      end else if (take) begin
        crc_q    <= crc_next;
        in_frame <= !s_beat.last;
        if (!in_frame) begin
          frm_mode <= mode;
        end
        if (s_beat.last) begin
          if (is_gen) begin
            gen_pend <= 1'b1;  // CRC beat follows.
          end else begin
            frame_done <= 1'b1;
            crc_err    <= is_chk && chk_bad;
          end
        end
      end
    end
  end

  // Output beat and frame CRC.
  always_ff @(posedge clk) begin
    if (emit_crc) begin
      m_beat.data <= crc_gen;
      m_beat.last <= 1'b1;
      m_beat.err  <= 1'b0;
      last_crc    <= crc_gen;
    end else if (take) begin
      m_beat.data <= s_beat.data;
      m_beat.last <= s_beat.last && !is_gen;
      m_beat.err  <= s_beat.last && is_chk && chk_bad;
      if (s_beat.last && !is_gen) begin
        last_crc <= is_chk ? (crc_base ^ CRC_XOROUT) : (crc_next ^ CRC_XOROUT);
      end
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_err_with_done: assert property (@(posedge clk) disable iff (!arst_n)
    crc_err |-> frame_done)
    else $error("crc_err without frame_done");

  a_err_on_last: assert property (@(posedge clk) disable iff (!arst_n)
    m_valid && m_beat.err |-> m_beat.last)
    else $error("err set on a beat that is not last");

endmodule

// File: rtl/crcgc_regfile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CRC-32 generate/check register file.
// Four-phase req/ack slave with control, sticky status,
// frame and error counters, last CRC and interrupt.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "crcgc_macros.svh"

module crcgc_regfile (
  input  logic                     clk,
  input  logic                     arst_n,

  input  logic                     reg_req,
  input  logic                     reg_we,
  input  logic [`CRCGC_ADDR_W-1:0] reg_addr,
  input  logic [31:0]              reg_wdata,
  output logic                     reg_ack,
  output logic [31:0]              reg_rdata,

  output crcgc_pkg::crcgc_mode_e   mode,

  input  logic                     frame_done,
  input  logic                     crc_err,
  input  logic [31:0]              last_crc,

  output logic                     irq
);

  import crcgc_pkg::*;

  logic                    acc_done;  // Request already served.
  logic                    do_acc;
  logic                    wr_ctrl;
  logic                    wr_sts;
  logic [1:0]              ctrl_mode;
  logic                    irq_en;
  logic                    sts_err;
  logic [`CRCGC_CNT_W-1:0] frames_cnt;
  logic [`CRCGC_CNT_W-1:0] errors_cnt;
  logic [31:0]             last_crc_q;
  logic [31:0]             rd_mux;

  assign do_acc  = reg_req && !acc_done;
  assign wr_ctrl = do_acc && reg_we && (reg_addr == `CRCGC_ADDR_CTRL);
  assign wr_sts  = do_acc && reg_we && (reg_addr == `CRCGC_ADDR_STATUS);

  assign reg_ack = acc_done;
  assign mode    = crcgc_mode_e'(ctrl_mode);
  assign irq     = sts_err && irq_en;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read decode
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    rd_mux = 32'd0;  // Unmapped reads as zero.
    case (reg_addr)
      `CRCGC_ADDR_CTRL:     rd_mux = {29'd0, irq_en, ctrl_mode};
      `CRCGC_ADDR_STATUS:   rd_mux = {31'd0, sts_err};
      `CRCGC_ADDR_FRAMES:   rd_mux = {{(32-`CRCGC_CNT_W){1'b0}}, frames_cnt};
      `CRCGC_ADDR_ERRORS:   rd_mux = {{(32-`CRCGC_CNT_W){1'b0}}, errors_cnt};
      `CRCGC_ADDR_LAST_CRC: rd_mux = last_crc_q;
      default:              rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (do_acc) begin
      reg_rdata <= reg_we ? 32'd0 : rd_mux;
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registers
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_done   <= 1'b0;
      ctrl_mode  <= 2'd0;
      irq_en     <= 1'b0;
      sts_err    <= 1'b0;
      frames_cnt <= '0;
      errors_cnt <= '0;
      last_crc_q <= 32'd0;
    end else begin
      acc_done <= reg_req;  // Ack follows req by one cycle.
      if (wr_ctrl) begin
        ctrl_mode <= reg_wdata[1:0];
        irq_en    <= reg_wdata[2];
      end
      if (crc_err) begin
        sts_err <= 1'b1;  // New error beats the clear.
      end else if (wr_sts && reg_wdata[0]) begin
        sts_err <= 1'b0;
      end
      if (frame_done) begin
        frames_cnt <= frames_cnt + 1'b1;
        last_crc_q <= last_crc;
      end
      if (crc_err) begin
        errors_cnt <= errors_cnt + 1'b1;
      end
    end
  end

endmodule

// File: rtl/crcgc.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CRC-32 generate/check top level.
// Input skid buffer, core, output skid buffer, register file.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "crcgc_macros.svh"

module crcgc (
  input  logic                     clk,
  input  logic                     arst_n,

  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic [`CRCGC_DATA_W-1:0] in_data,
  input  logic                     in_last,

  output logic                     out_valid,
  input  logic                     out_ready,
  output logic [`CRCGC_DATA_W-1:0] out_data,
  output logic                     out_last,
  output logic                     out_err,

  input  logic                     reg_req,
  input  logic                     reg_we,
  input  logic [`CRCGC_ADDR_W-1:0] reg_addr,
  input  logic [31:0]              reg_wdata,
  output logic                     reg_ack,
  output logic [31:0]              reg_rdata,

  output logic                     irq
);

  import crcgc_pkg::*;

  in_beat_t    ib_in;
  in_beat_t    core_s_beat;
  logic        core_s_valid;
  logic        core_s_ready;
  out_beat_t   core_m_beat;
  logic        core_m_valid;
  logic        core_m_ready;
  out_beat_t   ob_out;
  crcgc_mode_e mode;
  logic        frame_done;
  logic        crc_err;
  logic [31:0] last_crc;

  assign ib_in.data = in_data;
  assign ib_in.last = in_last;

  assign out_data = ob_out.data;
  assign out_last = ob_out.last;
  assign out_err  = ob_out.err;

  stream_skid_buf #(.payload_t(in_beat_t)) u_ib (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_valid (in_valid),
    .s_ready (in_ready),
    .s_data  (ib_in),
    .m_valid (core_s_valid),
    .m_ready (core_s_ready),
    .m_data  (core_s_beat)
  );

  crcgc_core u_core (
    .clk        (clk),
    .arst_n     (arst_n),
    .s_valid    (core_s_valid),
    .s_ready    (core_s_ready),
    .s_beat     (core_s_beat),
    .m_valid    (core_m_valid),
    .m_ready    (core_m_ready),
    .m_beat     (core_m_beat),
    .mode       (mode),
    .frame_done (frame_done),
    .crc_err    (crc_err),
    .last_crc   (last_crc)
  );

  stream_skid_buf #(.payload_t(out_beat_t)) u_ob (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_valid (core_m_valid),
    .s_ready (core_m_ready),
    .s_data  (core_m_beat),
    .m_valid (out_valid),
    .m_ready (out_ready),
    .m_data  (ob_out)
  );

  crcgc_regfile u_regfile (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_req    (reg_req),
    .reg_we     (reg_we),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_ack    (reg_ack),
    .reg_rdata  (reg_rdata),
    .mode       (mode),
    .frame_done (frame_done),
    .crc_err    (crc_err),
    .last_crc   (last_crc),
    .irq        (irq)
  );

endmodule

// File: tb/tb_crcgc.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CRC-32 generate/check testbench.
// Random frames in pass, generate and check modes against a
// bit-serial CRC model, register port and interrupt checks.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "crcgc_macros.svh"

module tb_crcgc;

  localparam int KIND_PASS = 0;
  localparam int KIND_GEN  = 1;
  localparam int KIND_CHK  = 2;
  localparam int SB_DEPTH  = 256;

  logic                     clk;
  logic                     arst_n;
  logic                     in_valid;
  logic                     in_ready;
  logic [`CRCGC_DATA_W-1:0] in_data;
  logic                     in_last;
  logic                     out_valid;
  logic                     out_ready;
  logic [`CRCGC_DATA_W-1:0] out_data;
  logic                     out_last;
  logic                     out_err;
  logic                     reg_req;
  logic                     reg_we;
  logic [`CRCGC_ADDR_W-1:0] reg_addr;
  logic [31:0]              reg_wdata;
  logic                     reg_ack;
  logic [31:0]              reg_rdata;
  logic                     irq;

  integer      seed = 58;
  integer      ready_seed;
  logic        ready_random;
  int          assert_errs = 0;  // Counted by concurrent assertions.
  int          check_errs = 0;
  int          test_base;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          frames_sent = 0;
  int          wr_ptr = 0;
  int          rd_ptr = 0;
  logic [31:0] exp_data [0:SB_DEPTH-1];
  logic        exp_last [0:SB_DEPTH-1];
  logic        exp_err  [0:SB_DEPTH-1];
  logic [31:0] frame_crc;

  crcgc uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .in_last   (in_last),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .out_err   (out_err),
    .reg_req   (reg_req),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_ack   (reg_ack),
    .reg_rdata (reg_rdata),
    .irq       (irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and scoreboard
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Reflected CRC-32, one data bit per step, bit 0 first.
  function automatic logic [31:0] crc_fold_word(input logic [31:0] crc,
                                                input logic [31:0] word);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 32; i++) begin
      fb = c[0] ^ word[i];
      c  = c >> 1;
      if (fb) begin
        c = c ^ 32'hEDB8_8320;
      end
    end
    return c;
  endfunction

  function automatic int rand_len();
    return 1 + ($unsigned($random(seed)) % 6);
  endfunction

  task push_expected(input logic [31:0] data, input logic last, input logic err);
    exp_data[wr_ptr % SB_DEPTH] = data;
    exp_last[wr_ptr % SB_DEPTH] = last;
    exp_err[wr_ptr % SB_DEPTH]  = err;
    wr_ptr = wr_ptr + 1;
  endtask

  always @(posedge clk) begin
    if (arst_n && out_valid && out_ready) begin
      rd_ptr <= rd_ptr + 1;
    end
  end

  a_out_match: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && out_ready |-> (wr_ptr != rd_ptr)
      && out_data == exp_data[rd_ptr % SB_DEPTH]
      && out_last == exp_last[rd_ptr % SB_DEPTH]
      && out_err  == exp_err[rd_ptr % SB_DEPTH])
    else begin
      $display("[FAIL] %0t: output beat %0d got %h/%b/%b, expected %h/%b/%b (queued %0d)",
               $time, rd_ptr, out_data, out_last, out_err,
               exp_data[rd_ptr % SB_DEPTH], exp_last[rd_ptr % SB_DEPTH],
               exp_err[rd_ptr % SB_DEPTH], wr_ptr - rd_ptr);
      assert_errs++;
    end

  a_err_only_last: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && out_err |-> out_last)
    else begin
      $display("[FAIL] %0t: out_err set on a beat without out_last", $time);
      assert_errs++;
    end

  a_ack_release: assert property (@(posedge clk) disable iff (!arst_n)
    reg_ack && !reg_req |=> !reg_ack)
    else begin
      $display("[FAIL] %0t: reg_ack held after reg_req dropped", $time);
      assert_errs++;
    end

  // Random back-pressure, own stream so driver order does not matter.
  initial begin
    out_ready  = 1'b1;
    ready_seed = seed;
    forever begin
      @(posedge clk);
      #5;
      if (ready_random) begin
        out_ready = ($random(ready_seed) % 2) == 0;
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Drivers
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task abort_run(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Simulation FAILED");
    $finish;
  endtask

  // Called at edge plus 5, in_ready is registered and stable here.
  task drive_beat(input logic [31:0] data, input logic last);
    int n;
    n         = 0;
    in_valid  = 1'b1;
    in_data   = data;
    in_last   = last;
    while (!in_ready) begin
      @(posedge clk);
      #5;
      n++;
      if (n > 200) abort_run("input stream never became ready");
    end
    @(posedge clk);  // Beat taken on this edge.
    #5;
    in_valid = 1'b0;
  endtask

  task send_frame(input int kind, input int len, input logic corrupt,
                  output logic [31:0] crc_out);
    logic [31:0] crc;
    logic [31:0] d;
    logic        last;
    crc = 32'hFFFF_FFFF;
    for (int i = 0; i < len; i++) begin
      d    = $random(seed);
      crc  = crc_fold_word(crc, d);
      last = (i == len - 1);
      if (kind == KIND_PASS) begin
        push_expected(d, last, 1'b0);
        drive_beat(d, last);
      end else if (kind == KIND_GEN) begin
        push_expected(d, 1'b0, 1'b0);  // Last moves to the CRC beat.
        drive_beat(d, last);
      end else begin
        push_expected(d, 1'b0, 1'b0);
        drive_beat(d, 1'b0);
      end
    end
    crc = crc ^ 32'hFFFF_FFFF;
    if (kind == KIND_GEN) begin
      push_expected(crc, 1'b1, 1'b0);
    end else if (kind == KIND_CHK) begin
      d = corrupt ? (crc ^ 32'h0000_0100) : crc;
      push_expected(d, 1'b1, corrupt);
      drive_beat(d, 1'b1);
    end
    crc_out     = crc;
    frames_sent = frames_sent + 1;
  endtask

  task wait_drain(input int limit);
    int n;
    n = 0;
    while (wr_ptr != rd_ptr) begin
      @(posedge clk);
      #5;
      n++;
      if (n > limit) abort_run("expected output beats never arrived");
    end
  endtask

  task wait_ack(input logic level);
    int n;
    n = 0;
    while (reg_ack !== level) begin
      @(posedge clk);
      #5;
      n++;
      if (n > 20) abort_run("register port did not complete its handshake");
    end
  endtask

  task reg_write(input logic [`CRCGC_ADDR_W-1:0] addr, input logic [31:0] data);
    reg_req   = 1'b1;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    wait_ack(1'b1);
    reg_req = 1'b0;
    wait_ack(1'b0);
  endtask

  task reg_read(input logic [`CRCGC_ADDR_W-1:0] addr, output logic [31:0] data);
    reg_req  = 1'b1;
    reg_we   = 1'b0;
    reg_addr = addr;
    wait_ack(1'b1);
    data    = reg_rdata;  // Valid while ack is high.
    reg_req = 1'b0;
    wait_ack(1'b0);
  endtask

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks and reporting
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task check_level(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
      check_errs++;
    end
  endtask

  task check_reg(input string what, input logic [`CRCGC_ADDR_W-1:0] addr,
                 input logic [31:0] exp);
    logic [31:0] got;
    reg_read(addr, got);
    assert (got === exp) else begin
      $display("[FAIL] %0t: %s read %h, expected %h", $time, what, got, exp);
      check_errs++;
    end
  endtask

  task start_test();
    test_base = assert_errs + check_errs;
  endtask

  task finish_test(input string name);
    if (assert_errs + check_errs == test_base) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, assert_errs + check_errs - test_base);
    end
  endtask

  initial begin
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_data      = '0;
    in_last      = 1'b0;
    reg_req      = 1'b0;
    reg_we       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    ready_random = 1'b0;
    repeat (2) @(posedge clk);
    #5;
    arst_n = 1'b1;

    start_test();
    check_level("out_valid", out_valid, 1'b0);
    check_level("reg_ack", reg_ack, 1'b0);
    check_level("irq", irq, 1'b0);
    check_level("in_ready", in_ready, 1'b1);
    // Known answer, CRC-32 of four zero bytes.
    assert ((crc_fold_word(32'hFFFF_FFFF, 32'd0) ^ 32'hFFFF_FFFF) == 32'h2144_DF1C)
      else begin
        $display("[FAIL] %0t: CRC model known answer wrong", $time);
        check_errs++;
      end
    check_reg("CTRL", `CRCGC_ADDR_CTRL, 32'd0);
    check_reg("STATUS", `CRCGC_ADDR_STATUS, 32'd0);
    check_reg("FRAMES", `CRCGC_ADDR_FRAMES, 32'd0);
    check_reg("ERRORS", `CRCGC_ADDR_ERRORS, 32'd0);
    finish_test("reset state");

    start_test();
    reg_write(`CRCGC_ADDR_CTRL, 32'd0);
    repeat (4) send_frame(KIND_PASS, rand_len(), 1'b0, frame_crc);
    wait_drain(200);
    check_reg("FRAMES", `CRCGC_ADDR_FRAMES, frames_sent);
    finish_test("pass mode");

    start_test();
    reg_write(`CRCGC_ADDR_CTRL, 32'd1);
    repeat (3) send_frame(KIND_GEN, rand_len(), 1'b0, frame_crc);
    wait_drain(200);
    check_reg("LAST_CRC", `CRCGC_ADDR_LAST_CRC, frame_crc);
    check_reg("FRAMES", `CRCGC_ADDR_FRAMES, frames_sent);
    finish_test("generate mode");

    start_test();
    reg_write(`CRCGC_ADDR_CTRL, 32'd2);
    send_frame(KIND_CHK, rand_len(), 1'b0, frame_crc);
    wait_drain(200);
    check_reg("ERRORS", `CRCGC_ADDR_ERRORS, 32'd0);
    check_reg("STATUS", `CRCGC_ADDR_STATUS, 32'd0);
    check_reg("LAST_CRC", `CRCGC_ADDR_LAST_CRC, frame_crc);
    send_frame(KIND_CHK, rand_len(), 1'b1, frame_crc);
    wait_drain(200);
    check_reg("ERRORS", `CRCGC_ADDR_ERRORS, 32'd1);
    check_reg("STATUS", `CRCGC_ADDR_STATUS, 32'd1);
    check_level("irq", irq, 1'b0);
    reg_write(`CRCGC_ADDR_CTRL, 32'd6);  // Check mode, irq enabled.
    check_level("irq", irq, 1'b1);
    finish_test("check mode");

    start_test();
    reg_write(`CRCGC_ADDR_STATUS, 32'd1);
    check_reg("STATUS", `CRCGC_ADDR_STATUS, 32'd0);
    check_level("irq", irq, 1'b0);
    check_reg("FRAMES", `CRCGC_ADDR_FRAMES, frames_sent);
    check_reg("ERRORS", `CRCGC_ADDR_ERRORS, 32'd1);
    finish_test("status clear");

    start_test();
    reg_write(`CRCGC_ADDR_CTRL, 32'd1);
    ready_random = 1'b1;
    repeat (6) send_frame(KIND_GEN, rand_len(), 1'b0, frame_crc);
    wait_drain(3000);
    ready_random = 1'b0;
    check_reg("FRAMES", `CRCGC_ADDR_FRAMES, frames_sent);
    check_reg("LAST_CRC", `CRCGC_ADDR_LAST_CRC, frame_crc);
    finish_test("back-pressure");

    $display("tests ok: %0d, tests with errors: %0d, failed checks: %0d",
             tests_ok, tests_bad, assert_errs + check_errs);
    if (tests_bad == 0 && assert_errs + check_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/crcgc_pkg.sv
rtl/stream_skid_buf.sv
rtl/crcgc_core.sv
rtl/crcgc_regfile.sv
rtl/crcgc.sv
tb/tb_crcgc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_crcgc_sim

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_crcgc \
  -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation run returned status $run_status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1
